/* files.f */
+incdir+include
verilog/bk_mem_pkg.sv
verilog/bk_page_regs.sv
verilog/bk_addr_map.sv
verilog/bk_bus_ctrl.sv
verilog/bk_mem_array.sv
verilog/bk_memory_top.sv
tests/tb_bk_memory.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the BK0011M mapper testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_bk_memory -o tb_bk_memory

./obj_dir/tb_bk_memory 2>&1 | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

/* include/bk_mem_ref.svh */
// Reference model of the BK0011M mapper, page register and ROM presence for the testbench
`ifndef BK_MEM_REF_SVH
`define BK_MEM_REF_SVH

word_t      ref_mem [logic [18:0]];	// Shadow memory by word index
page_reg_u  ref_page;
rom_avail_t ref_avail;

function automatic void ref_ldr(input ldr_req_t r);
	ref_mem[r.addr[19:1]] = r.data;
	if (r.addr[19:16] == 4'hE && r.data != '0) ref_avail[r.addr[15:14]] = 1'b1;
endfunction

function automatic phys_addr_t ref_ram(input logic [2:0] code);
	logic [2:0] idx;
	case (code)
		3'b110: idx = 3'd0;
		3'b000: idx = 3'd1;
		3'b010: idx = 3'd2;
		3'b011: idx = 3'd3;
		3'b100: idx = 3'd4;
		3'b001: idx = 3'd5;
		3'b111: idx = 3'd6;
		default: idx = 3'd7;
	endcase
	return {3'b000, idx, 14'd0};
endfunction

// Expected answer for one request, applying its side effects to the shadow state
function automatic cpu_rsp_t ref_cpu(input cpu_req_t r);
	phys_addr_t pa;
	logic       ok;
	logic [1:0] rp;
	word_t      w;
	cpu_rsp_t   rsp;
	ok = 1'b1;
	rp = ref_page.f.rom10 ? 2'd0 : ref_page.f.rom11 ? 2'd1 : ref_page.f.rom12 ? 2'd2 : 2'd3;
	case (r.addr[15:14])
		2'b00: pa = {6'd0, r.addr[13:0]};
		2'b01: pa = ref_ram(ref_page.f.win1) + r.addr[13:0];
		2'b10: begin
			if (ref_page.f.rom10 | ref_page.f.rom11 | ref_page.f.rom12 | ref_page.f.rom13) begin
				pa = rom_p10 + {rp, 14'd0} + r.addr[13:0];
				ok = ref_avail[rp];
			end else begin
				pa = ref_ram(ref_page.f.win2) + r.addr[13:0];
			end
		end
		default: pa = (r.addr[13] ? mstd_rom : bios11) + r.addr[12:0];
	endcase
	ok = r.sys ? r.we : ok && !(r.we && pa >= rom_start) && (r.addr < io_base);
	rsp = '{rdata: '0, err: !ok};
	w = ref_mem.exists(pa[19:1]) ? ref_mem[pa[19:1]] : '0;
	if (ok && r.sys) begin
		if (r.wdata[11] && r.be[1]) ref_page.raw = r.wdata;
	end else if (ok && r.we) begin
		if (r.be[0]) w[7:0] = r.wdata[7:0];
		if (r.be[1]) w[15:8] = r.wdata[15:8];
		ref_mem[pa[19:1]] = w;
	end else if (ok) begin
		rsp.rdata = w;
	end
	return rsp;
endfunction

`endif

/* tests/tb_bk_memory.sv */
// Testbench of the BK0011M memory mapper, checked against a reference model of the page map
`timescale 1ns/1ps
`default_nettype none

module tb_bk_memory
	import bk_mem_pkg::*;
();

	`include "bk_mem_ref.svh"

	logic     clk_sys = 1'b0;
	logic     reset;
	cpu_req_t cpu_req;
	logic     cpu_valid;
	logic     cpu_ready;
	cpu_rsp_t cpu_rsp;
	logic     rsp_valid;
	logic     rsp_ready;
	ldr_req_t ldr_req;
	logic     ldr_valid;
	logic     ldr_ready;

	cpu_rsp_t exp_q [$];	// Expected answers in request order
	int       seed = 63847;
	int       wait_limit = 200;	// Cycles per wait
	int       rsp_errors;
	int       ready_errors;
	int       other_errors;
	logic     traffic_on;	// Random back-pressure on

	bk_memory_top bk_memory_top_inst (.*);

	always #5 clk_sys = ~clk_sys;

	task automatic check_rsp(input string name, input cpu_rsp_t got, input cpu_rsp_t exp);
		if (got !== exp) begin
			rsp_errors++;
			$display("[FAIL] %s rdata %h err %h, expected rdata %h err %h",
				name, got.rdata, got.err, exp.rdata, exp.err);
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			ready_errors++;
			$display("[FAIL] %s %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		other_errors++;
		$display("Timed out waiting for %s", what);
	endtask

	// Starts and ends 1 ns after a rising edge
	task automatic send_cpu(input cpu_addr_t addr, input word_t wdata, input logic we,
		input logic [1:0] be, input logic sys);
		int n;
		n         = 0;
		cpu_req   = '{addr: addr, wdata: wdata, we: we, be: be, sys: sys};
		cpu_valid = 1'b1;
		@(negedge clk_sys);
		while (!cpu_ready && n < wait_limit) begin
			n++;
			@(negedge clk_sys);
		end
		if (!cpu_ready) report_timeout("cpu_ready");
		@(posedge clk_sys);
		#1;
		cpu_valid = 1'b0;
	endtask

	task automatic cpu_read(input cpu_addr_t addr);
		send_cpu(addr, 16'h0000, 1'b0, 2'b11, 1'b0);
	endtask

	task automatic page_write(input word_t value, input logic [1:0] be);
		send_cpu(16'o177716, value, 1'b1, be, 1'b1);
	endtask

	task automatic send_ldr(input phys_addr_t addr, input word_t data);
		int n;
		n         = 0;
		ldr_req   = '{addr: addr, data: data};
		ldr_valid = 1'b1;
		@(negedge clk_sys);
		while (!ldr_ready && n < wait_limit) begin
			n++;
			@(negedge clk_sys);
		end
		if (!ldr_ready) report_timeout("ldr_ready");
		@(posedge clk_sys);
		#1;
		ldr_valid = 1'b0;
	endtask

	task automatic drain_responses;
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < wait_limit) begin
			n++;
			@(posedge clk_sys);
			#1;
		end
		if (exp_q.size() != 0) report_timeout("outstanding responses");
	endtask

	task automatic random_cpu;
		word_t     r;
		cpu_addr_t off;
		r   = $random(seed);
		off = {11'd0, r[4:1], 1'b0};	// Loaded words only
		case (r[7:5])
			3'd0: cpu_read(off);
			3'd1: send_cpu(off, word_t'($random(seed)), 1'b1,
				(r[9:8] == 2'b00) ? 2'b11 : r[9:8], 1'b0);
			3'd2: cpu_read(16'o040000 + off);
			3'd3: cpu_read(16'o100000 + off);
			3'd4: send_cpu(16'o100000 + off, word_t'($random(seed)), 1'b1, 2'b11, 1'b0);
			3'd5: page_write((r & 16'h771B) | 16'h0800, 2'b11);
			3'd6: cpu_read(16'o177000 + off);
			default: cpu_read(16'o160000 + off);
		endcase
	endtask

	// Scoreboard, sampled mid-cycle where every signal is settled
	always @(negedge clk_sys) begin
		check_ready("ldr_ready", ldr_ready, 1'b1);
		if (reset) begin
			check_ready("cpu_ready", cpu_ready, 1'b0);
			check_ready("rsp_valid", rsp_valid, 1'b0);
		end else begin
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("Response arrived with no request outstanding");
				end else begin
					check_rsp("cpu_rsp", cpu_rsp, exp_q.pop_front());
				end
			end
			if (ldr_valid) begin
				check_ready("cpu_ready", cpu_ready, 1'b0);	// Loader wins the cycle
				ref_ldr(ldr_req);
			end else if (exp_q.size() == 0) begin
				check_ready("cpu_ready", cpu_ready, 1'b1);	// Nothing in flight
			end
			if (cpu_valid && cpu_ready) exp_q.push_back(ref_cpu(cpu_req));
		end
	end

	always @(posedge clk_sys) begin
		#1;
		rsp_ready = traffic_on ? (($random(seed) & 3) != 0) : 1'b1;
	end

	initial begin
		word_t     w;
		cpu_addr_t a;
		word_t     sel [5];
		reset = 1'b1;
		cpu_valid = 1'b0;
		cpu_req = '0;
		rsp_ready = 1'b1;
		ldr_valid = 1'b0;
		ldr_req = '0;
		traffic_on = 1'b0;
		ref_page = '0;
		ref_avail = '0;
		rsp_errors = 0;
		ready_errors = 0;
		other_errors = 0;
		sel = '{16'h0810, 16'h0818, 16'h081A, 16'h0803, 16'h0802};
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// First 32 bytes of every RAM page, BIOS11 and monitor ROM
		for (int p = 0; p < 8; p++)
			for (int i = 0; i < 16; i++)
				send_ldr(phys_addr_t'(p * 'h4000 + i * 2), word_t'($random(seed)));
		for (int i = 0; i < 16; i++) begin
			send_ldr(bios11 + phys_addr_t'(i * 2), word_t'($random(seed)));
			send_ldr(mstd_rom + phys_addr_t'(i * 2), word_t'($random(seed)));
		end
		for (int i = 0; i < 16; i++) begin
			cpu_read(cpu_addr_t'(i * 2));
			cpu_read(16'o140000 + cpu_addr_t'(i * 2));
			cpu_read(16'o160000 + cpu_addr_t'(i * 2));
		end
		for (int i = 0; i < 8; i++) begin
			w = $random(seed);
			send_ldr({6'd0, w[13:1], 1'b0}, word_t'($random(seed)));
			cpu_read({2'b00, w[13:1], 1'b0});
		end
		drain_responses();

		// Every window code, plus page writes that must not take effect
		for (int c = 0; c < 8; c++) begin
			page_write({1'b0, 3'(c), 1'b1, ~3'(c), 8'h00}, 2'b11);
			w = $random(seed);
			a = 16'o040000 + {11'd0, w[4:1], 1'b0};
			cpu_read(a);
			cpu_read(16'o100000 + {11'd0, w[8:5], 1'b0});
			send_cpu(a, word_t'($random(seed)), 1'b1, (c % 2 == 1) ? 2'b01 : 2'b10, 1'b0);
			cpu_read(a);
			send_cpu(16'o100000 + {11'd0, w[8:5], 1'b0}, word_t'($random(seed)), 1'b1,
				(c % 2 == 1) ? 2'b10 : 2'b01, 1'b0);
			page_write({1'b0, 3'(c + 3), 1'b0, 3'(c + 5), 8'h00}, 2'b11);	// No strobe
			page_write({1'b0, 3'(c + 2), 1'b1, 3'(c + 1), 8'h00}, 2'b01);	// Low byte only
			cpu_read(a);
			cpu_read(16'o100000 + {11'd0, w[8:5], 1'b0});
		end
		drain_responses();

		// Optional ROM pages, selected before and after they are loaded
		page_write(16'h0810, 2'b11);
		for (int p = 0; p < 4; p++) begin
			cpu_read(16'o100000 + cpu_addr_t'(p * 2));
			if (p == 2) page_write(16'h0811, 2'b11);
			for (int i = 0; i < 16; i++)
				send_ldr(rom_p10 + phys_addr_t'(p * 'h4000 + i * 2), word_t'($random(seed)) | 16'h1);
		end
		foreach (sel[k]) begin
			page_write(sel[k], 2'b11);
			w = $random(seed);
			a = 16'o100000 + {11'd0, w[4:1], 1'b0};
			cpu_read(a);
			send_cpu(a, word_t'($random(seed)), 1'b1, 2'b11, 1'b0);
			cpu_read(a);
		end
		page_write(16'h0800, 2'b11);
		drain_responses();

		// I/O space, system reads and a BIOS11 write
		cpu_read(16'o177000);
		cpu_read(16'o177776);
		send_cpu(16'o177100, 16'h1234, 1'b1, 2'b11, 1'b0);
		send_cpu(16'o177716, 16'h0000, 1'b0, 2'b11, 1'b1);
		send_cpu(16'o140000, 16'hBEEF, 1'b1, 2'b11, 1'b0);
		cpu_read(16'o140000);
		drain_responses();

		// Mixed traffic under back-pressure
		traffic_on = 1'b1;
		fork
			for (int n = 0; n < 300; n++) random_cpu();
			for (int n = 0; n < 100; n++) begin
				w = $random(seed);
				if (w[0]) begin
					send_ldr({15'd0, w[4:1], 1'b0}, word_t'($random(seed)));
				end else begin
					@(posedge clk_sys);
					#1;
				end
			end
		join
		traffic_on = 1'b0;
		drain_responses();

		$display("Errors: response %0d, ready %0d, other %0d",
			rsp_errors, ready_errors, other_errors);
		if (rsp_errors + ready_errors + other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/bk_addr_map.sv */
// Translation of a BK0011M CPU address into a physical address, with refusal checks
`timescale 1ns/1ps
`default_nettype none

module bk_addr_map
	import bk_mem_pkg::*;
(
	input  cpu_addr_t  addr,
	input  logic       we,
	input  logic       sys,
	input  page_reg_u  page,
	input  rom_avail_t avail,
	output phys_addr_t phys,
	output logic       refuse
);

	phys_addr_t  base;
	logic [13:0] offset;
	logic [20:0] phys_sum;	// Extra bit shows a carry past 1 MB
	logic        rom_ok;

	// Page code to RAM page, same order as the real hardware
	function automatic phys_addr_t ram_page(input logic [2:0] code);
		case (code)
			3'b110:  return ram_p00;
			3'b000:  return ram_p01;
			3'b010:  return ram_p02;
			3'b011:  return ram_p03;
			3'b100:  return ram_p04;
			3'b001:  return ram_p05;
			3'b111:  return ram_p06;
			default: return ram_p07;
		endcase
	endfunction

	always_comb begin
		base   = ram_p00;
		offset = addr[13:0];
		rom_ok = 1'b1;
		case (addr[15:13])
			3'b000, 3'b001: base = ram_p00;	// Bank 0 is fixed
			3'b010, 3'b011: base = ram_page(page.f.win1);
			3'b110: begin
				base   = bios11;
				offset = {1'b0, addr[12:0]};	// 8 KB ROM
			end
			3'b111: begin
				base   = mstd_rom;
				offset = {1'b0, addr[12:0]};
			end
			default: begin
				// Window 2, ROM selects win over the RAM code
				if (page.f.rom10) begin
					base   = rom_p10;
					rom_ok = avail[0];
				end else if (page.f.rom11) begin
					base   = rom_p11;
					rom_ok = avail[1];
				end else if (page.f.rom12) begin
					base   = rom_p12;
					rom_ok = avail[2];
				end else if (page.f.rom13) begin
					base   = rom_p13;
					rom_ok = avail[3];
				end else begin
					base = ram_page(page.f.win2);
				end
			end
		endcase
	end

	assign phys_sum = {1'b0, base} + {7'd0, offset};
	assign phys     = phys_sum[19:0];

	// System register only takes writes; memory refuses ROM writes, holes and I/O
	assign refuse = sys ? !we
	                    : ((we && (phys >= rom_start)) || !rom_ok || (addr >= io_base));

	always_comb begin
		if (!refuse) begin
			assert (phys_sum < mem_end)
				else $error("addr_map: address %h maps past 1 MB", addr);
		end
	end

endmodule

`default_nettype wire

/* verilog/bk_bus_ctrl.sv */
// Valid/ready control of the BK0011M CPU and loader ports with the response register
`timescale 1ns/1ps
`default_nettype none

module bk_bus_ctrl
	import bk_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  cpu_req_t    cpu_req,
	input  logic        cpu_valid,
	output logic        cpu_ready,
	output cpu_rsp_t    cpu_rsp,
	output logic        rsp_valid,
	input  logic        rsp_ready,
	input  ldr_req_t    ldr_req,
	input  logic        ldr_valid,
	output logic        ldr_ready,
	input  phys_addr_t  phys,
	input  logic        refuse,
	output logic        sys_we,
	output logic        ldr_we,
	output logic        mem_we,
	output logic [1:0]  mem_be,
	output logic [18:0] mem_addr,
	output word_t       mem_wdata,
	output logic        mem_rd,
	input  word_t       mem_rdata
);

	logic cpu_acc;
	logic cpu_mem;		// Accepted CPU request touches the array
	logic s1_valid;		// Request waiting on the array read
	logic s1_err;
	logic s1_mem;		// Response takes its data from the array
	logic s1_adv;

	assign ldr_ready = 1'b1;	// Loader is never stalled
	assign ldr_we    = ldr_valid;

	// Response slot frees when empty or being taken this cycle
	assign s1_adv    = !rsp_valid || rsp_ready;
	assign cpu_ready = !reset && !ldr_valid && !(s1_valid && !s1_adv);
	assign cpu_acc   = cpu_valid && cpu_ready;
	assign cpu_mem   = cpu_acc && !cpu_req.sys && !refuse;

	assign sys_we = cpu_acc && cpu_req.sys && cpu_req.we;
	assign mem_rd = cpu_mem && !cpu_req.we;

	// Loader and CPU never share a cycle, so the mux follows ldr_valid
	assign mem_we    = ldr_valid || (cpu_mem && cpu_req.we);
	assign mem_be    = ldr_valid ? 2'b11 : cpu_req.be;
	assign mem_addr  = ldr_valid ? ldr_req.addr[19:1] : phys[19:1];
	assign mem_wdata = ldr_valid ? ldr_req.data : cpu_req.wdata;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_valid  <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			if (s1_adv) rsp_valid <= s1_valid;
			if (s1_adv || !s1_valid) s1_valid <= cpu_acc;
		end
	end

	// Array stage tag and held response
	always_ff @(posedge clk_sys) begin
		if (cpu_acc) begin
			s1_err <= refuse;
			s1_mem <= mem_rd;
		end
		if (s1_adv && s1_valid) begin
			cpu_rsp.rdata <= s1_mem ? mem_rdata : '0;	// Writes and refusals read zero
			cpu_rsp.err   <= s1_err;
		end
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(cpu_rsp)))
		else $error("bus_ctrl: held response changed before it was taken");

endmodule

`default_nettype wire

/* verilog/bk_mem_array.sv */
// Flat 1 MB word memory with byte lane writes and a registered read
`timescale 1ns/1ps
`default_nettype none

module bk_mem_array
	import bk_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        we,
	input  logic [1:0]  be,
	input  logic [18:0] addr,
	input  word_t       wdata,
	input  logic        rd,
	output word_t       rdata
);

	logic [1:0][7:0] mem [mem_words];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			if (be[0]) mem[addr][0] <= wdata[7:0];
			if (be[1]) mem[addr][1] <= wdata[15:8];
		end
	end

	// Read data holds until the next read
	always_ff @(posedge clk_sys) begin
		if (rd) begin
			rdata <= mem[addr];
		end
	end

	assert property (@(posedge clk_sys) we |-> (be != 2'b00))
		else $error("mem_array: write at %h with no byte enabled", addr);

endmodule

`default_nettype wire

/* verilog/bk_mem_pkg.sv */
// BK0011M memory mapper package with the memory map, bus types and page register layout
`default_nettype none

package bk_mem_pkg;

	typedef logic [19:0] phys_addr_t;	// Physical byte address into 1 MB
	typedef logic [15:0] cpu_addr_t;
	typedef logic [15:0] word_t;
	typedef logic [3:0]  rom_avail_t;	// Presence of P10, P11, P12, P13

	// RAM pages, 16 KB each
	localparam phys_addr_t ram_p00 = 20'h00000;
	localparam phys_addr_t ram_p01 = 20'h04000;
	localparam phys_addr_t ram_p02 = 20'h08000;
	localparam phys_addr_t ram_p03 = 20'h0C000;
	localparam phys_addr_t ram_p04 = 20'h10000;
	localparam phys_addr_t ram_p05 = 20'h14000;
	localparam phys_addr_t ram_p06 = 20'h18000;
	localparam phys_addr_t ram_p07 = 20'h1C000;

	// Everything from here up is read only for the CPU
	localparam phys_addr_t rom_start = 20'hE0000;
	localparam phys_addr_t rom_p10   = 20'hE0000;	// BASIC11
	localparam phys_addr_t rom_p11   = 20'hE4000;	// BASIC11 and BIOS extension
	localparam phys_addr_t rom_p12   = 20'hE8000;
	localparam phys_addr_t rom_p13   = 20'hEC000;	// Debugger
	localparam phys_addr_t bios11    = 20'hF0000;
	localparam phys_addr_t mstd_rom  = 20'hFE000;	// Monitor ROM

	localparam logic [20:0] mem_end   = 21'h100000;	// One past the last byte
	localparam cpu_addr_t   io_base   = 16'o177000;
	localparam int unsigned mem_words = 524288;

	// Page register fields as the CPU writes them
	typedef struct packed {
		logic       rsvd15;
		logic [2:0] win1;	// Page code for 040000
		logic       strobe;	// Write only takes effect with this set
		logic [2:0] win2;	// Page code for 100000
		logic [2:0] rsvd7_5;
		logic       rom13;
		logic       rom12;
		logic       rsvd2;
		logic       rom11;
		logic       rom10;
	} page_fields_t;

	typedef union packed {
		word_t        raw;
		page_fields_t f;
	} page_reg_u;

	typedef struct packed {
		cpu_addr_t  addr;
		word_t      wdata;
		logic       we;
		logic [1:0] be;
		logic       sys;	// Access to the system register
	} cpu_req_t;

	typedef struct packed {
		word_t rdata;
		logic  err;
	} cpu_rsp_t;

	typedef struct packed {
		phys_addr_t addr;
		word_t      data;
	} ldr_req_t;

endpackage

`default_nettype wire

/* verilog/bk_memory_top.sv */
// BK0011M memory mapper top level with page registers, address map, bus control and memory
`timescale 1ns/1ps
`default_nettype none

module bk_memory_top
	import bk_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  cpu_req_t cpu_req,
	input  logic     cpu_valid,
	output logic     cpu_ready,
	output cpu_rsp_t cpu_rsp,
	output logic     rsp_valid,
	input  logic     rsp_ready,
	input  ldr_req_t ldr_req,
	input  logic     ldr_valid,
	output logic     ldr_ready
);

	page_reg_u   page;
	rom_avail_t  avail;
	phys_addr_t  phys;
	logic        refuse;
	logic        sys_we;
	logic        ldr_we;
	logic        mem_we;
	logic [1:0]  mem_be;
	logic [18:0] mem_addr;
	word_t       mem_wdata;
	logic        mem_rd;
	word_t       mem_rdata;

	// Register writes reuse the array's data and address lines
	bk_page_regs bk_page_regs_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sys_we   (sys_we),
		.wdata    (mem_wdata),
		.be       (mem_be),
		.ldr_we   (ldr_we),
		.ldr_addr ({mem_addr, 1'b0}),
		.page     (page),
		.avail    (avail)
	);

	bk_addr_map bk_addr_map_inst (
		.addr   (cpu_req.addr),
		.we     (cpu_req.we),
		.sys    (cpu_req.sys),
		.page   (page),
		.avail  (avail),
		.phys   (phys),
		.refuse (refuse)
	);

	bk_bus_ctrl bk_bus_ctrl_inst (.*);

	bk_mem_array bk_mem_array_inst (
		.clk_sys (clk_sys),
		.we      (mem_we),
		.be      (mem_be),
		.addr    (mem_addr),
		.wdata   (mem_wdata),
		.rd      (mem_rd),
		.rdata   (mem_rdata)
	);

endmodule

`default_nettype wire

/* verilog/bk_page_regs.sv */
// Page register and optional ROM presence flags of the BK0011M mapper
`timescale 1ns/1ps
`default_nettype none

module bk_page_regs
	import bk_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       sys_we,
	input  word_t      wdata,
	input  logic [1:0] be,
	input  logic       ldr_we,
	input  phys_addr_t ldr_addr,
	output page_reg_u  page,
	output rom_avail_t avail
);

	page_reg_u  wr_word;
	logic       page_load;
	logic       in_rom_pages;
	logic [1:0] rom_idx;

	assign wr_word = page_reg_u'(wdata);

	// The strobe bit sits in the high byte, so that lane must be written too
	assign page_load = sys_we && wr_word.f.strobe && be[1];

	// Optional ROM pages share the top nibble of P10, one 16 KB slot each
	assign in_rom_pages = (ldr_addr[19:16] == rom_p10[19:16]);
	assign rom_idx      = ldr_addr[15:14];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page <= '0;
		end else if (page_load) begin
			page <= wr_word;
		end
	end

	// A page counts as present once any nonzero word is loaded into it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			avail <= '0;
		end else if (ldr_we && in_rom_pages && (wdata != '0)) begin
			avail[rom_idx] <= 1'b1;
		end
	end

	// Loader has priority in the bus controller, so both strobes never meet
	assert property (@(posedge clk_sys) disable iff (reset) !(sys_we && ldr_we))
		else $error("page_regs: system write and loader write in the same cycle");

endmodule

`default_nettype wire
